// ==== logic/stashControl.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Access FSM with path-read, scan and
// writeback slot counters
// ----------------------------------------

module stashControl #(
	parameter int StashCapacity = 16,
	parameter int BucketSize = 2
) (
	input logic Clock,
	input logic reset,
	input logic startAccess,
	input stashPkg::leafT accessLeaf,
	input logic writeValid,
	input logic readReady,
	output logic writeReady,
	output logic readValid,
	output logic scanStep,
	output logic takeSlot,
	output stashPkg::levelT levelNow,
	output stashPkg::leafT accessLeafHeld,
	output stashPkg::stashStateT state
);

	localparam int PathBlocks = BucketSize * (stashPkg::LeafWidth + 1);
	localparam int PathCountWidth = $clog2(PathBlocks + 1);
	localparam int ScanCountWidth = $clog2(StashCapacity + 1);

	logic [PathCountWidth-1:0] pathCount;
	logic [PathCountWidth-1:0] slotCount;
	logic [ScanCountWidth-1:0] scanCount;
	logic writeAccept;
	logic pathDone;
	logic scanDone;
	logic slotsDone;

	// Handshake qualifiers
	assign writeReady = (state == stashPkg::stPathRead);
	assign readValid = (state == stashPkg::stWriteback);
	assign writeAccept = writeReady && writeValid;
	assign takeSlot = readValid && readReady;

	// One settle cycle after the last entry
	assign scanStep = (state == stashPkg::stScan)
		&& (scanCount != ScanCountWidth'(StashCapacity));

	assign pathDone = writeAccept && (pathCount == PathCountWidth'(PathBlocks - 1));
	assign scanDone = (scanCount == ScanCountWidth'(StashCapacity));
	assign slotsDone = takeSlot && (slotCount == PathCountWidth'(PathBlocks - 1));

	// Leaf bucket first, root last
	assign levelNow = stashPkg::levelT'(stashPkg::LeafWidth - int'(slotCount) / BucketSize);

	// ----------------------------------------
	// State and counters
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= stashPkg::stIdle;
			pathCount <= '0;
			scanCount <= '0;
			slotCount <= '0;
		end else begin
			case (state)
				stashPkg::stIdle: begin
					if (startAccess) begin
						state <= stashPkg::stPathRead;
					end
				end
				stashPkg::stPathRead: begin
					if (pathDone) begin
						state <= stashPkg::stScan;
						pathCount <= '0;
					end else if (writeAccept) begin
						pathCount <= pathCount + 1'b1;
					end
				end
				stashPkg::stScan: begin
					if (scanDone) begin
						state <= stashPkg::stWriteback;
						scanCount <= '0;
					end else begin
						scanCount <= scanCount + 1'b1;
					end
				end
				stashPkg::stWriteback: begin
					// Slot waits while readReady is low
					if (slotsDone) begin
						state <= stashPkg::stIdle;
						slotCount <= '0;
					end else if (takeSlot) begin
						slotCount <= slotCount + 1'b1;
					end
				end
				default: state <= stashPkg::stIdle;
			endcase
		end
	end

	// Path leaf held for the whole access
	always_ff @(posedge Clock) begin
		if ((state == stashPkg::stIdle) && startAccess) begin
			accessLeafHeld <= accessLeaf;
		end
	end

endmodule

// ==== logic/stashCore.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Stash entry storage, occupancy count
// and overflow / almost-full status
// ----------------------------------------

module stashCore #(
	parameter int StashCapacity = 16,
	parameter int BucketSize = 2
) (
	input logic Clock,
	input logic reset,
	input stashPkg::dataT writeData,
	input stashPkg::pAddrT writePAddr,
	input stashPkg::leafT writeLeaf,
	input logic writeValid,
	input stashPkg::stashStateT state,
	input logic pickIndexTake,
	output stashPkg::dataT readData,
	output stashPkg::pAddrT readPAddr,
	output stashPkg::leafT readLeaf,
	output logic almostFull,
	output logic overflow,
	stashScanBus.core scanBus
);

	localparam int IndexWidth = $clog2(StashCapacity);
	localparam int CountWidth = $clog2(StashCapacity + 1);
	// Blocks on one root-to-leaf path
	localparam int PathBlocks = BucketSize * (stashPkg::LeafWidth + 1);
	// Room for one more full path must remain
	localparam int AlmostFullLevel =
		(StashCapacity > PathBlocks) ? StashCapacity - PathBlocks : 0;

	// Entry payload
	stashPkg::dataT dataMem [StashCapacity];
	stashPkg::pAddrT addrMem [StashCapacity];
	stashPkg::leafT leafMem [StashCapacity];

	logic [StashCapacity-1:0] validBits;
	logic [CountWidth-1:0] occupancy;
	logic [IndexWidth-1:0] freeIndex;
	logic freeFound;
	logic writeAccept;
	logic writeReal;
	logic storeEntry;
	logic removeEntry;

	// ----------------------------------------
	// Write side
	// ----------------------------------------

	// Same condition as writeReady in the controller
	assign writeAccept = writeValid && (state == stashPkg::stPathRead);
	// Dummies are counted but never kept
	assign writeReal = writeAccept && (writePAddr != '0);
	assign storeEntry = writeReal && freeFound;
	// Dummy slots remove nothing
	assign removeEntry = pickIndexTake && scanBus.pickFound;

	// Lowest free entry
	always_comb begin
		freeFound = 1'b0;
		freeIndex = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (!validBits[i]) begin
				freeFound = 1'b1;
				freeIndex = IndexWidth'(i);
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (storeEntry) begin
			dataMem[freeIndex] <= writeData;
			addrMem[freeIndex] <= writePAddr;
			leafMem[freeIndex] <= writeLeaf;
		end
	end

	// Valid bits, occupancy and sticky overflow
	always_ff @(posedge Clock) begin
		if (reset) begin
			validBits <= '0;
			occupancy <= '0;
			overflow <= 1'b0;
		end else begin
			// Store and remove live in different states
			if (storeEntry) begin
				validBits[freeIndex] <= 1'b1;
				occupancy <= occupancy + 1'b1;
			end else if (removeEntry) begin
				validBits[scanBus.pickIndex] <= 1'b0;
				occupancy <= occupancy - 1'b1;
			end
			// Real block lost to a full stash
			if (writeReal && !freeFound) begin
				overflow <= 1'b1;
			end
		end
	end

	assign almostFull = (occupancy >= CountWidth'(AlmostFullLevel));

	// ----------------------------------------
	// Scan and read side
	// ----------------------------------------

	assign scanBus.scanEntryLeaf = leafMem[scanBus.scanIndex];
	assign scanBus.scanEntryValid = validBits[scanBus.scanIndex];
	assign scanBus.entryValid = validBits;

	// Zeros form the dummy block
	assign readData = scanBus.pickFound ? dataMem[scanBus.pickIndex] : '0;
	assign readPAddr = scanBus.pickFound ? addrMem[scanBus.pickIndex] : '0;
	assign readLeaf = scanBus.pickFound ? leafMem[scanBus.pickIndex] : '0;

endmodule

// ==== logic/stashPkg.sv ====
// ----------------------------------------
// Stash widths, vector types and the
// access controller state encoding
// ----------------------------------------

package stashPkg;

	// ----------------------------------------
	// Tree geometry
	// ----------------------------------------

	// Leaf label bits, tree has LeafWidth+1 levels
	localparam int LeafWidth = 3;

	// Enough bits to name levels 0 to LeafWidth
	localparam int LevelWidth = $clog2(LeafWidth + 1);

	// ----------------------------------------
	// Block fields
	// ----------------------------------------

	// One data word per block
	localparam int DataWidth = 32;

	// Physical address, zero marks a dummy block
	localparam int PAddrWidth = 16;

	typedef logic [DataWidth-1:0] dataT;
	typedef logic [PAddrWidth-1:0] pAddrT;
	typedef logic [LeafWidth-1:0] leafT;

	// Level 0 is the root bucket
	typedef logic [LevelWidth-1:0] levelT;

	// ----------------------------------------
	// Access sequencing
	// ----------------------------------------

	typedef enum logic [1:0] {
		// Waiting for a start pulse
		stIdle,
		// Taking in the blocks of the path
		stPathRead,
		// Computing per-entry levels
		stScan,
		// Emitting the path, leaf bucket first
		stWriteback
	} stashStateT;

endpackage

// ==== logic/stashScanBus.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Entry storage to scan table link
// ----------------------------------------

interface stashScanBus #(
	parameter int StashCapacity = 16
);

	localparam int IndexWidth = $clog2(StashCapacity);

	// Entry being scanned, named by the table
	logic [IndexWidth-1:0] scanIndex;
	stashPkg::leafT scanEntryLeaf;
	logic scanEntryValid;

	// Live valid bits of every entry
	logic [StashCapacity-1:0] entryValid;

	// Writeback choice for the current slot
	logic [IndexWidth-1:0] pickIndex;
	logic pickFound;

	// Storage side
	modport core (
		input scanIndex,
		input pickIndex,
		input pickFound,
		output scanEntryLeaf,
		output scanEntryValid,
		output entryValid
	);

	// Level table side
	modport scanTable (
		output scanIndex,
		output pickIndex,
		output pickFound,
		input scanEntryLeaf,
		input scanEntryValid,
		input entryValid
	);

endinterface

// ==== logic/stashScanTable.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Per-entry path level table and the
// writeback priority search
// ----------------------------------------

module stashScanTable #(
	parameter int StashCapacity = 16
) (
	input logic Clock,
	input logic reset,
	input logic scanStep,
	input stashPkg::leafT accessLeaf,
	input stashPkg::levelT levelNow,
	stashScanBus.scanTable scanBus
);

	localparam int IndexWidth = $clog2(StashCapacity);

	// Deepest shared level per entry
	stashPkg::levelT levels [StashCapacity];
	// Set only for entries that were valid at scan time
	logic [StashCapacity-1:0] levelMark;
	logic [IndexWidth-1:0] scanIndex;
	stashPkg::levelT scanLevel;

	// Matching low bits from bit 0, the root branch, upward
	function automatic stashPkg::levelT sharedLevel(
		input stashPkg::leafT entryLeaf,
		input stashPkg::leafT pathLeaf
	);
		stashPkg::levelT depth;
		logic matching;
		depth = '0;
		matching = 1'b1;
		for (int i = 0; i < stashPkg::LeafWidth; i++) begin
			if (matching && (entryLeaf[i] == pathLeaf[i])) begin
				depth = depth + 1'b1;
			end else begin
				matching = 1'b0;
			end
		end
		// At most LeafWidth by construction
		return depth;
	endfunction

	// ----------------------------------------
	// Scan walk
	// ----------------------------------------

	assign scanBus.scanIndex = scanIndex;
	assign scanLevel = sharedLevel(scanBus.scanEntryLeaf, accessLeaf);

	always_ff @(posedge Clock) begin
		if (reset) begin
			scanIndex <= '0;
		end else if (scanStep && (scanIndex != IndexWidth'(StashCapacity - 1))) begin
			scanIndex <= scanIndex + 1'b1;
		end else begin
			// Rest at entry 0 between scans
			scanIndex <= '0;
		end
	end

	always_ff @(posedge Clock) begin
		if (scanStep) begin
			levels[scanIndex] <= scanLevel;
		end
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			levelMark <= '0;
		end else begin
			// Entries taken at writeback lose their mark
			levelMark <= levelMark & scanBus.entryValid;
			// Empty entry gets an invalid mark
			if (scanStep) begin
				levelMark[scanIndex] <= scanBus.scanEntryValid;
			end
		end
	end

	// ----------------------------------------
	// Writeback pick where the lowest index wins
	// ----------------------------------------

	always_comb begin
		scanBus.pickFound = 1'b0;
		scanBus.pickIndex = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (scanBus.entryValid[i] && levelMark[i] && (levels[i] >= levelNow)) begin
				scanBus.pickFound = 1'b1;
				scanBus.pickIndex = IndexWidth'(i);
			end
		end
	end

endmodule

// ==== logic/stashTop.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Path ORAM stash backend top level
// ----------------------------------------

module stashTop #(
	parameter int StashCapacity = 16,
	parameter int BucketSize = 2
) (
	input logic Clock,
	input logic reset,
	input logic startAccess,
	input stashPkg::leafT accessLeaf,
	input stashPkg::dataT writeData,
	input stashPkg::pAddrT writePAddr,
	input stashPkg::leafT writeLeaf,
	input logic writeValid,
	output logic writeReady,
	output stashPkg::dataT readData,
	output stashPkg::pAddrT readPAddr,
	output stashPkg::leafT readLeaf,
	output logic readValid,
	input logic readReady,
	output logic almostFull,
	output logic overflow
);

	stashPkg::stashStateT state;
	stashPkg::levelT levelNow;
	stashPkg::leafT heldLeaf;
	logic scanStep;
	logic takeSlot;

	// Storage to level table
	stashScanBus #(.StashCapacity(StashCapacity)) scanBus0 ();

	stashControl #(
		.StashCapacity(StashCapacity),
		.BucketSize(BucketSize)
	) control0 (
		.Clock(Clock),
		.reset(reset),
		.startAccess(startAccess),
		.accessLeaf(accessLeaf),
		.writeValid(writeValid),
		.readReady(readReady),
		.writeReady(writeReady),
		.readValid(readValid),
		.scanStep(scanStep),
		.takeSlot(takeSlot),
		.levelNow(levelNow),
		.accessLeafHeld(heldLeaf),
		.state(state)
	);

	stashCore #(
		.StashCapacity(StashCapacity),
		.BucketSize(BucketSize)
	) core0 (
		.Clock(Clock),
		.reset(reset),
		.writeData(writeData),
		.writePAddr(writePAddr),
		.writeLeaf(writeLeaf),
		.writeValid(writeValid),
		.state(state),
		.pickIndexTake(takeSlot),
		.readData(readData),
		.readPAddr(readPAddr),
		.readLeaf(readLeaf),
		.almostFull(almostFull),
		.overflow(overflow),
		.scanBus(scanBus0.core)
	);

	// Levels are taken against the held path leaf
	stashScanTable #(
		.StashCapacity(StashCapacity)
	) scanTable0 (
		.Clock(Clock),
		.reset(reset),
		.scanStep(scanStep),
		.accessLeaf(heldLeaf),
		.levelNow(levelNow),
		.scanBus(scanBus0.scanTable)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the stash testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f stashTop.f \
	--top-module stashTopTb \
	-o stashSim

./obj_dir/stashSim 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== stashTop.f ====
logic/stashPkg.sv
logic/stashScanBus.sv
logic/stashCore.sv
logic/stashScanTable.sv
logic/stashControl.sv
logic/stashTop.sv
testbench/stashCheck_sva.sv
testbench/stashTopTb.sv

// ==== testbench/stashCheck_sva.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Handshake and output stability checks
// ----------------------------------------

module stashCheckSva (
	input logic Clock,
	input logic reset,
	input logic writeReady,
	input logic readValid,
	input logic readReady,
	input stashPkg::dataT readData,
	input stashPkg::pAddrT readPAddr,
	input stashPkg::leafT readLeaf
);

	// Path read and writeback never overlap
	noReadWriteOverlap: assert property (@(posedge Clock) disable iff (reset)
		!(readValid && writeReady))
		else $error("readValid and writeReady high together");

	// Dummy block carries no data
	dummyDataZero: assert property (@(posedge Clock) disable iff (reset)
		(readValid && (readPAddr == '0)) |-> (readData == '0))
		else $error("dummy output block with nonzero data");

	// Stalled slot holds its block
	stallHoldsBlock: assert property (@(posedge Clock) disable iff (reset)
		(readValid && !readReady) |=>
			($stable(readData) && $stable(readPAddr) && $stable(readLeaf)))
		else $error("output block changed while readReady was low");

endmodule

bind stashTop stashCheckSva check0 (
	.Clock(Clock),
	.reset(reset),
	.writeReady(writeReady),
	.readValid(readValid),
	.readReady(readReady),
	.readData(readData),
	.readPAddr(readPAddr),
	.readLeaf(readLeaf)
);

// ==== testbench/stashTopTb.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Stash testbench with directed tests, a
// greedy writeback model and a watchdog
// ----------------------------------------

module stashTopTb;

	localparam int StashCapacity = 16;
	localparam int BucketSize = 2;
	localparam int LeafWidth = stashPkg::LeafWidth;
	localparam int PathBlocks = BucketSize * (LeafWidth + 1);
	localparam int AlmostFullLevel = StashCapacity - PathBlocks;
	// Up to 40 accesses of about 60 cycles each
	localparam int WatchdogCycles = 40 * 60;

	logic Clock;
	logic reset;
	logic startAccess;
	stashPkg::leafT accessLeaf;
	stashPkg::dataT writeData;
	stashPkg::pAddrT writePAddr;
	stashPkg::leafT writeLeaf;
	logic writeValid;
	logic writeReady;
	stashPkg::dataT readData;
	stashPkg::pAddrT readPAddr;
	stashPkg::leafT readLeaf;
	logic readValid;
	logic readReady;
	logic almostFull;
	logic overflow;

	int mismatchCount;
	int failureCount;
	logic [31:0] rngState;
	stashPkg::pAddrT nextAddr;

	// Model entries where the lowest index wins
	logic modelValid [StashCapacity];
	stashPkg::dataT modelData [StashCapacity];
	stashPkg::pAddrT modelAddr [StashCapacity];
	stashPkg::leafT modelLeaf [StashCapacity];
	logic modelOverflow;

	// Blocks of the next path read
	stashPkg::dataT pathData [PathBlocks];
	stashPkg::pAddrT pathAddr [PathBlocks];
	stashPkg::leafT pathLeaf [PathBlocks];

	stashTop #(
		.StashCapacity(StashCapacity),
		.BucketSize(BucketSize)
	) dut0 (
		.Clock(Clock),
		.reset(reset),
		.startAccess(startAccess),
		.accessLeaf(accessLeaf),
		.writeData(writeData),
		.writePAddr(writePAddr),
		.writeLeaf(writeLeaf),
		.writeValid(writeValid),
		.writeReady(writeReady),
		.readData(readData),
		.readPAddr(readPAddr),
		.readLeaf(readLeaf),
		.readValid(readValid),
		.readReady(readReady),
		.almostFull(almostFull),
		.overflow(overflow)
	);

	always #10 Clock = ~Clock;

	// ----------------------------------------
	// Random numbers and reference model
	// ----------------------------------------

	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// Levels walked from the root before the first differing bit
	function automatic int pathDepth(input stashPkg::leafT a, input stashPkg::leafT b);
		stashPkg::leafT diff;
		int depth;
		diff = a ^ b;
		depth = 0;
		while ((depth < LeafWidth) && !diff[depth]) begin
			depth++;
		end
		return depth;
	endfunction

	function automatic int modelCount();
		int count;
		count = 0;
		for (int i = 0; i < StashCapacity; i++) begin
			if (modelValid[i]) begin
				count++;
			end
		end
		return count;
	endfunction

	task automatic modelClear();
		for (int i = 0; i < StashCapacity; i++) begin
			modelValid[i] = 1'b0;
		end
		modelOverflow = 1'b0;
	endtask

	task automatic modelWrite(input stashPkg::dataT d, input stashPkg::pAddrT a,
		input stashPkg::leafT l);
		int slot;
		slot = -1;
		// Dummies never enter the stash
		if (a != '0) begin
			for (int i = StashCapacity - 1; i >= 0; i--) begin
				if (!modelValid[i]) begin
					slot = i;
				end
			end
			if (slot < 0) begin
				modelOverflow = 1'b1;
			end else begin
				modelValid[slot] = 1'b1;
				modelData[slot] = d;
				modelAddr[slot] = a;
				modelLeaf[slot] = l;
			end
		end
	endtask

	// Greedy pick for one writeback slot
	task automatic modelTake(input stashPkg::leafT leaf, input int slotNo,
		output stashPkg::dataT d, output stashPkg::pAddrT a, output stashPkg::leafT l);
		int level;
		int pick;
		level = LeafWidth - slotNo / BucketSize;
		pick = -1;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (modelValid[i] && (pathDepth(modelLeaf[i], leaf) >= level)) begin
				pick = i;
			end
		end
		if (pick < 0) begin
			d = '0;
			a = '0;
			l = '0;
		end else begin
			d = modelData[pick];
			a = modelAddr[pick];
			l = modelLeaf[pick];
			modelValid[pick] = 1'b0;
		end
	endtask

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------

	task automatic checkData(input string testName, input string what,
		input stashPkg::dataT expected, input stashPkg::dataT actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s %s: expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkPAddr(input string testName, input string what,
		input stashPkg::pAddrT expected, input stashPkg::pAddrT actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s %s: expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkLeaf(input string testName, input string what,
		input stashPkg::leafT expected, input stashPkg::leafT actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s %s: expected %b actual %b", testName, what, expected, actual);
		end
	endtask

	task automatic checkFlag(input string testName, input string what,
		input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("MISMATCH %s %s: expected %b actual %b", testName, what, expected, actual);
		end
	endtask

	task automatic reportFailure(input string message);
		failureCount++;
		$display("%s", message);
	endtask

	// ----------------------------------------
	// Bus drivers on the falling edge
	// ----------------------------------------

	task automatic applyReset();
		@(negedge Clock);
		reset = 1'b1;
		repeat (8) @(negedge Clock);
		reset = 1'b0;
		modelClear();
	endtask

	task automatic sendBlock(input stashPkg::dataT d, input stashPkg::pAddrT a,
		input stashPkg::leafT l);
		writeData = d;
		writePAddr = a;
		writeLeaf = l;
		writeValid = 1'b1;
		while (!writeReady) begin
			@(negedge Clock);
		end
		// Accepted at the coming rising edge
		@(negedge Clock);
	endtask

	// Random gaps in readReady when stall is set
	task automatic receiveSlot(input bit stall, output stashPkg::dataT d,
		output stashPkg::pAddrT a, output stashPkg::leafT l);
		bit waiting;
		waiting = 1'b1;
		while (waiting) begin
			if (readValid && !(stall && ((nextRand() % 3) == 0))) begin
				readReady = 1'b1;
				d = readData;
				a = readPAddr;
				l = readLeaf;
				waiting = 1'b0;
			end else begin
				readReady = 1'b0;
			end
			@(negedge Clock);
		end
		readReady = 1'b0;
	endtask

	// Fill one path entry as a dummy unless isReal
	task automatic setBlock(input int i, input bit isReal, input stashPkg::leafT l);
		pathData[i] = stashPkg::dataT'(nextRand());
		pathLeaf[i] = l;
		if (isReal) begin
			pathAddr[i] = nextAddr;
			nextAddr = nextAddr + 1'b1;
		end else begin
			pathAddr[i] = '0;
		end
	endtask

	// One full access through path read, scan and writeback
	task automatic runAccess(input string testName, input stashPkg::leafT leaf, input bit stall);
		stashPkg::dataT expData;
		stashPkg::dataT gotData;
		stashPkg::pAddrT expAddr;
		stashPkg::pAddrT gotAddr;
		stashPkg::leafT expLeaf;
		stashPkg::leafT gotLeaf;
		@(negedge Clock);
		startAccess = 1'b1;
		accessLeaf = leaf;
		@(negedge Clock);
		startAccess = 1'b0;
		for (int i = 0; i < PathBlocks; i++) begin
			modelWrite(pathData[i], pathAddr[i], pathLeaf[i]);
			sendBlock(pathData[i], pathAddr[i], pathLeaf[i]);
			// Occupancy steps by one block here
			checkFlag(testName, $sformatf("almostFull after block %0d", i),
				modelCount() >= AlmostFullLevel, almostFull);
		end
		writeValid = 1'b0;
		while (!readValid) begin
			@(negedge Clock);
		end
		// Stash is at its fullest here
		checkFlag(testName, "almostFull", modelCount() >= AlmostFullLevel, almostFull);
		checkFlag(testName, "overflow", modelOverflow, overflow);
		for (int s = 0; s < PathBlocks; s++) begin
			modelTake(leaf, s, expData, expAddr, expLeaf);
			receiveSlot(stall, gotData, gotAddr, gotLeaf);
			checkData(testName, $sformatf("slot %0d data", s), expData, gotData);
			checkPAddr(testName, $sformatf("slot %0d addr", s), expAddr, gotAddr);
			checkLeaf(testName, $sformatf("slot %0d leaf", s), expLeaf, gotLeaf);
		end
		checkFlag(testName, "readValid after path", 1'b0, readValid);
		checkFlag(testName, "almostFull after path", modelCount() >= AlmostFullLevel, almostFull);
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------

	task automatic testAfterReset();
		checkFlag("afterReset", "writeReady", 1'b0, writeReady);
		checkFlag("afterReset", "readValid", 1'b0, readValid);
		checkFlag("afterReset", "almostFull", 1'b0, almostFull);
		checkFlag("afterReset", "overflow", 1'b0, overflow);
	endtask

	task automatic testDummyPath();
		for (int i = 0; i < PathBlocks; i++) begin
			setBlock(i, 1'b0, stashPkg::leafT'(nextRand()));
		end
		runAccess("dummyPath", 3'b110, 1'b0);
	endtask

	task automatic testRealBlocks();
		// Leaf 101 gives two full matches, one at level 2, one at 1 and three at root
		setBlock(0, 1'b1, 3'b101);
		setBlock(1, 1'b1, 3'b110);
		setBlock(2, 1'b1, 3'b101);
		setBlock(3, 1'b0, 3'b000);
		setBlock(4, 1'b1, 3'b111);
		setBlock(5, 1'b1, 3'b001);
		setBlock(6, 1'b1, 3'b000);
		setBlock(7, 1'b1, 3'b000);
		runAccess("realBlocks", 3'b101, 1'b0);
		// Leftover block now matches fully
		for (int i = 0; i < PathBlocks; i++) begin
			setBlock(i, 1'b0, 3'b000);
		end
		runAccess("realBlocksLater", 3'b000, 1'b0);
	endtask

	task automatic testBackPressure();
		applyReset();
		for (int i = 0; i < PathBlocks; i++) begin
			setBlock(i, 1'b1, stashPkg::leafT'(nextRand()));
		end
		runAccess("backPressure", 3'b011, 1'b1);
		for (int i = 0; i < PathBlocks; i++) begin
			setBlock(i, (i % 2) == 0, stashPkg::leafT'(nextRand()));
		end
		runAccess("backPressureDrain", 3'b100, 1'b1);
	endtask

	task automatic testStatusFlags();
		applyReset();
		// Bit 0 set against path leaf 000, so only root slots drain
		for (int n = 0; n < 3; n++) begin
			for (int i = 0; i < PathBlocks; i++) begin
				setBlock(i, 1'b1, stashPkg::leafT'(nextRand()) | stashPkg::leafT'(1));
			end
			runAccess($sformatf("statusFlags%0d", n), 3'b000, 1'b0);
		end
	endtask

	task automatic testRandomAccesses();
		stashPkg::leafT leaf;
		bit stall;
		applyReset();
		for (int n = 0; n < 6; n++) begin
			for (int i = 0; i < PathBlocks; i++) begin
				setBlock(i, (nextRand() % 4) != 0, stashPkg::leafT'(nextRand()));
			end
			leaf = stashPkg::leafT'(nextRand());
			stall = (nextRand() & 32'd1) != 0;
			runAccess($sformatf("randomAccess%0d", n), leaf, stall);
		end
	endtask

	// ----------------------------------------
	// Run control
	// ----------------------------------------

	initial begin
		Clock = 1'b0;
		reset = 1'b1;
		startAccess = 1'b0;
		accessLeaf = '0;
		writeData = '0;
		writePAddr = '0;
		writeLeaf = '0;
		writeValid = 1'b0;
		readReady = 1'b0;
		mismatchCount = 0;
		failureCount = 0;
		rngState = 32'd8843;
		nextAddr = 16'h0001;
		applyReset();
		testAfterReset();
		testDummyPath();
		testRealBlocks();
		testBackPressure();
		testStatusFlags();
		testRandomAccesses();
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if ((mismatchCount == 0) && (failureCount == 0)) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Ends a run stuck on a handshake
	initial begin
		repeat (WatchdogCycles) @(posedge Clock);
		reportFailure("Watchdog expired, a handshake never completed");
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
